// File: src/pong_pkg.sv
package pong_pkg;

	// screen coordinate and 3-bit rgb pixel
	typedef logic [10:0] coord_t;
	typedef logic [2:0] colour_t;

	localparam coord_t SCREEN_W = 11'd320;
	localparam coord_t SCREEN_H = 11'd240;
	localparam coord_t BORDER_T = 11'd4;

	// object sizes in pixels
	localparam coord_t PADDLE_W = 11'd4;
	localparam coord_t PADDLE_H = 11'd20;
	localparam coord_t BALL_SIZE = 11'd8;

	// start positions are top left corners
	localparam coord_t P1_START_X = 11'd20;
	localparam coord_t P2_START_X = 11'd296;
	localparam coord_t PADDLE_START_Y = 11'd80;
	localparam coord_t BALL_START_X = 11'd160;
	localparam coord_t BALL_START_Y = 11'd120;

	// paddle corner keeps clear of the border strips
	localparam coord_t PADDLE_MIN = 11'd4;
	localparam coord_t PADDLE_MAX_X = 11'd296;
	localparam coord_t PADDLE_MAX_Y = 11'd216;

	localparam coord_t BALL_MIN = 11'd4;
	localparam coord_t BALL_MAX_X = 11'd308;
	localparam coord_t BALL_MAX_Y = 11'd228;

	localparam colour_t COLOUR_P1 = 3'b101;
	localparam colour_t COLOUR_P2 = 3'b010;
	localparam colour_t COLOUR_BALL = 3'b100;
	localparam colour_t COLOUR_BORDER = 3'b010;
	localparam colour_t COLOUR_BLACK = 3'b000;

	// cycles between drawing a frame and erasing it
	localparam int unsigned FRAME_WAIT = 200;

	typedef enum logic [3:0] {
		IDLE,
		DRAW_BORDER,
		DRAW_P1,
		DRAW_P2,
		DRAW_BALL,
		WAIT_FRAME,
		ERASE_P1,
		ERASE_P2,
		ERASE_BALL,
		UPDATE
	} game_state_t;

	typedef enum logic [2:0] {
		B_IDLE,
		B_TOP,
		B_BOTTOM,
		B_LEFT,
		B_RIGHT,
		B_DONE
	} border_state_t;

endpackage

// File: src/rect_raster.sv
`timescale 1ns/10ps

module rect_raster (
	input  logic             clock,
	input  logic             reset_n,
	input  logic             clear,
	input  logic             enable,
	input  pong_pkg::coord_t origin_x,
	input  pong_pkg::coord_t origin_y,
	input  pong_pkg::coord_t width,
	input  pong_pkg::coord_t height,
	output pong_pkg::coord_t pixel_x,
	output pong_pkg::coord_t pixel_y,
	output logic             done
);

	// offsets from the origin
	pong_pkg::coord_t col;
	pong_pkg::coord_t row;
	logic last_col;
	logic last_row;

	assign last_col = (col == width - 11'd1);
	assign last_row = (row == height - 11'd1);

	// high with the last pixel of the rectangle
	assign done = enable & last_col & last_row;

	assign pixel_x = origin_x + col;
	assign pixel_y = origin_y + row;

	always_ff @(posedge clock) begin
		if (reset_n || clear) begin
			col <= '0;
			row <= '0;
		end else if (enable) begin
			if (last_col) begin
				col <= '0;
				// wrap to the origin after the bottom row
				if (last_row) begin
					row <= '0;
				end else begin
					row <= row + 11'd1;
				end
			end else begin
				col <= col + 11'd1;
			end
		end
	end

endmodule

// File: src/paddle_motion.sv
`timescale 1ns/10ps

module paddle_motion (
	input  logic             clock,
	input  logic             reset_n,
	input  logic             clear,
	input  logic             update,
	input  pong_pkg::coord_t start_x,
	input  logic             up,
	input  logic             down,
	input  logic             left,
	input  logic             right,
	output pong_pkg::coord_t pos_x,
	output pong_pkg::coord_t pos_y
);

	logic step_up;
	logic step_down;
	logic step_left;
	logic step_right;

	// opposite buttons cancel, limits block the step
	assign step_up = up & ~down & (pos_y > pong_pkg::PADDLE_MIN);
	assign step_down = down & ~up & (pos_y < pong_pkg::PADDLE_MAX_Y);
	assign step_left = left & ~right & (pos_x > pong_pkg::PADDLE_MIN);
	assign step_right = right & ~left & (pos_x < pong_pkg::PADDLE_MAX_X);

	always_ff @(posedge clock) begin
		if (reset_n || clear) begin
			pos_x <= start_x;
			pos_y <= pong_pkg::PADDLE_START_Y;
		end else if (update) begin
			if (step_up) begin
				pos_y <= pos_y - 11'd1;
			end else if (step_down) begin
				pos_y <= pos_y + 11'd1;
			end
			if (step_left) begin
				pos_x <= pos_x - 11'd1;
			end else if (step_right) begin
				pos_x <= pos_x + 11'd1;
			end
		end
	end

endmodule

// File: src/ball_motion.sv
`timescale 1ns/10ps

module ball_motion (
	input  logic             clock,
	input  logic             reset_n,
	input  logic             clear,
	input  logic             update,
	input  pong_pkg::coord_t p1_x,
	input  pong_pkg::coord_t p1_y,
	input  pong_pkg::coord_t p2_x,
	input  pong_pkg::coord_t p2_y,
	output pong_pkg::coord_t ball_x,
	output pong_pkg::coord_t ball_y
);

	logic go_right;
	logic go_down;
	logic go_right_next;
	logic go_down_next;
	logic hit_p1;
	logic hit_p2;

	// ball square against a paddle rectangle
	function automatic logic overlaps(
		input pong_pkg::coord_t bx,
		input pong_pkg::coord_t by,
		input pong_pkg::coord_t px,
		input pong_pkg::coord_t py
	);
		logic x_hit;
		logic y_hit;
		x_hit = (bx < px + pong_pkg::PADDLE_W) && (px < bx + pong_pkg::BALL_SIZE);
		y_hit = (by < py + pong_pkg::PADDLE_H) && (py < by + pong_pkg::BALL_SIZE);
		return x_hit & y_hit;
	endfunction

	assign hit_p1 = overlaps(ball_x, ball_y, p1_x, p1_y);
	assign hit_p2 = overlaps(ball_x, ball_y, p2_x, p2_y);

	always_comb begin
		go_right_next = go_right;
		go_down_next = go_down;
		// walls first, so a paddle hit at the wall still flips
		if (ball_x == pong_pkg::BALL_MIN) begin
			go_right_next = 1'b1;
		end else if (ball_x == pong_pkg::BALL_MAX_X) begin
			go_right_next = 1'b0;
		end
		if (ball_y == pong_pkg::BALL_MIN) begin
			go_down_next = 1'b1;
		end else if (ball_y == pong_pkg::BALL_MAX_Y) begin
			go_down_next = 1'b0;
		end
		if (hit_p1 || hit_p2) begin
			go_right_next = ~go_right_next;
		end
	end

	always_ff @(posedge clock) begin
		if (reset_n || clear) begin
			ball_x <= pong_pkg::BALL_START_X;
			ball_y <= pong_pkg::BALL_START_Y;
			// serve towards the right and up
			go_right <= 1'b1;
			go_down <= 1'b0;
		end else if (update) begin
			go_right <= go_right_next;
			go_down <= go_down_next;
			ball_x <= go_right_next ? ball_x + 11'd1 : ball_x - 11'd1;
			ball_y <= go_down_next ? ball_y + 11'd1 : ball_y - 11'd1;
		end
	end

endmodule

// File: src/border_painter.sv
`timescale 1ns/10ps

module border_painter (
	input  logic             clock,
	input  logic             reset_n,
	input  logic             clear,
	input  logic             go,
	output pong_pkg::coord_t pixel_x,
	output pong_pkg::coord_t pixel_y,
	output logic             done
);

	pong_pkg::border_state_t state;
	pong_pkg::border_state_t state_next;
	pong_pkg::coord_t org_x;
	pong_pkg::coord_t org_y;
	pong_pkg::coord_t strip_w;
	pong_pkg::coord_t strip_h;
	logic strip_en;
	logic strip_done;

	// top strip starts in the go cycle, so no gap after go
	assign strip_en = (state == pong_pkg::B_IDLE) ? go :
		(state inside {pong_pkg::B_TOP, pong_pkg::B_BOTTOM, pong_pkg::B_LEFT,
		pong_pkg::B_RIGHT});

	assign done = (state == pong_pkg::B_DONE) | ((state == pong_pkg::B_RIGHT) & strip_done);

	always_comb begin
		org_x = '0;
		org_y = '0;
		strip_w = pong_pkg::SCREEN_W;
		strip_h = pong_pkg::BORDER_T;
		case (state)
			pong_pkg::B_BOTTOM: org_y = pong_pkg::SCREEN_H - pong_pkg::BORDER_T;
			pong_pkg::B_LEFT: begin
				strip_w = pong_pkg::BORDER_T;
				strip_h = pong_pkg::SCREEN_H;
			end
			pong_pkg::B_RIGHT: begin
				org_x = pong_pkg::SCREEN_W - pong_pkg::BORDER_T;
				strip_w = pong_pkg::BORDER_T;
				strip_h = pong_pkg::SCREEN_H;
			end
			default: ;
		endcase
	end

	always_comb begin
		state_next = state;
		case (state)
			pong_pkg::B_IDLE: if (go) state_next = pong_pkg::B_TOP;
			pong_pkg::B_TOP: if (strip_done) state_next = pong_pkg::B_BOTTOM;
			pong_pkg::B_BOTTOM: if (strip_done) state_next = pong_pkg::B_LEFT;
			pong_pkg::B_LEFT: if (strip_done) state_next = pong_pkg::B_RIGHT;
			pong_pkg::B_RIGHT: if (strip_done) state_next = pong_pkg::B_DONE;
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset_n || clear) begin
			state <= pong_pkg::B_IDLE;
		end else begin
			state <= state_next;
		end
	end

	rect_raster u_strip (
		.clock    (clock),
		.reset_n  (reset_n),
		.clear    (clear),
		.enable   (strip_en),
		.origin_x (org_x),
		.origin_y (org_y),
		.width    (strip_w),
		.height   (strip_h),
		.pixel_x  (pixel_x),
		.pixel_y  (pixel_y),
		.done     (strip_done)
	);

endmodule

// File: src/frame_sequencer.sv
`timescale 1ns/10ps

module frame_sequencer (
	input  logic              clock,
	input  logic              reset_n,
	input  logic              go,
	input  logic              border_done,
	input  logic              p1_done,
	input  logic              p2_done,
	input  logic              ball_done,
	output logic              border_go,
	output logic              p1_draw,
	output logic              p2_draw,
	output logic              ball_draw,
	output pong_pkg::colour_t draw_colour,
	output logic              update,
	output logic              object_clear
);

	pong_pkg::game_state_t state;
	pong_pkg::game_state_t state_next;
	logic [$clog2(pong_pkg::FRAME_WAIT)-1:0] wait_count;
	logic wait_over;

	assign wait_over = (wait_count == $bits(wait_count)'(pong_pkg::FRAME_WAIT - 1));

	always_comb begin
		state_next = state;
		case (state)
			pong_pkg::IDLE: if (go) state_next = pong_pkg::DRAW_BORDER;
			pong_pkg::DRAW_BORDER: if (border_done) state_next = pong_pkg::DRAW_P1;
			pong_pkg::DRAW_P1: if (p1_done) state_next = pong_pkg::DRAW_P2;
			pong_pkg::DRAW_P2: if (p2_done) state_next = pong_pkg::DRAW_BALL;
			pong_pkg::DRAW_BALL: if (ball_done) state_next = pong_pkg::WAIT_FRAME;
			pong_pkg::WAIT_FRAME: if (wait_over) state_next = pong_pkg::ERASE_P1;
			pong_pkg::ERASE_P1: if (p1_done) state_next = pong_pkg::ERASE_P2;
			pong_pkg::ERASE_P2: if (p2_done) state_next = pong_pkg::ERASE_BALL;
			pong_pkg::ERASE_BALL: if (ball_done) state_next = pong_pkg::UPDATE;
			pong_pkg::UPDATE: state_next = pong_pkg::DRAW_P1;
			default: state_next = pong_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset_n) begin
			state <= pong_pkg::IDLE;
		end else begin
			state <= state_next;
		end
	end

	// counts only inside WAIT_FRAME, parked at zero elsewhere
	always_ff @(posedge clock) begin
		if (reset_n || state != pong_pkg::WAIT_FRAME) begin
			wait_count <= '0;
		end else begin
			wait_count <= wait_count + 1'b1;
		end
	end

	assign border_go = (state == pong_pkg::DRAW_BORDER);
	assign p1_draw = (state == pong_pkg::DRAW_P1) | (state == pong_pkg::ERASE_P1);
	assign p2_draw = (state == pong_pkg::DRAW_P2) | (state == pong_pkg::ERASE_P2);
	assign ball_draw = (state == pong_pkg::DRAW_BALL) | (state == pong_pkg::ERASE_BALL);
	assign update = (state == pong_pkg::UPDATE);
	assign object_clear = (state == pong_pkg::IDLE);

	// erase states fall through to black
	always_comb begin
		case (state)
			pong_pkg::DRAW_BORDER: draw_colour = pong_pkg::COLOUR_BORDER;
			pong_pkg::DRAW_P1: draw_colour = pong_pkg::COLOUR_P1;
			pong_pkg::DRAW_P2: draw_colour = pong_pkg::COLOUR_P2;
			pong_pkg::DRAW_BALL: draw_colour = pong_pkg::COLOUR_BALL;
			default: draw_colour = pong_pkg::COLOUR_BLACK;
		endcase
	end

endmodule

// File: src/pong_top.sv
`timescale 1ns/10ps

module pong_top (
	input  logic              clock,
	input  logic              reset_n,
	input  logic              go,
	input  logic              p1_up,
	input  logic              p1_down,
	input  logic              p1_left,
	input  logic              p1_right,
	input  logic              p2_up,
	input  logic              p2_down,
	input  logic              p2_left,
	input  logic              p2_right,
	output pong_pkg::coord_t  x,
	output pong_pkg::coord_t  y,
	output pong_pkg::colour_t colour,
	output logic              write_en
);

	logic border_go, p1_draw, p2_draw, ball_draw;
	logic border_done, p1_done, p2_done, ball_done;
	logic update, object_clear;
	pong_pkg::colour_t draw_colour;
	pong_pkg::coord_t p1_x, p1_y, p2_x, p2_y, ball_x, ball_y;
	pong_pkg::coord_t border_px, border_py, p1_px, p1_py;
	pong_pkg::coord_t p2_px, p2_py, ball_px, ball_py;
	pong_pkg::coord_t sel_x, sel_y;
	pong_pkg::colour_t sel_colour;

	frame_sequencer u_seq (
		.clock(clock), .reset_n(reset_n), .go(go),
		.border_done(border_done), .p1_done(p1_done), .p2_done(p2_done),
		.ball_done(ball_done), .border_go(border_go), .p1_draw(p1_draw),
		.p2_draw(p2_draw), .ball_draw(ball_draw), .draw_colour(draw_colour),
		.update(update), .object_clear(object_clear)
	);

	border_painter u_border (
		.clock(clock), .reset_n(reset_n), .clear(object_clear), .go(border_go),
		.pixel_x(border_px), .pixel_y(border_py), .done(border_done)
	);

	paddle_motion u_p1_motion (
		.clock(clock), .reset_n(reset_n), .clear(object_clear), .update(update),
		.start_x(pong_pkg::P1_START_X), .up(p1_up), .down(p1_down),
		.left(p1_left), .right(p1_right), .pos_x(p1_x), .pos_y(p1_y)
	);

	paddle_motion u_p2_motion (
		.clock(clock), .reset_n(reset_n), .clear(object_clear), .update(update),
		.start_x(pong_pkg::P2_START_X), .up(p2_up), .down(p2_down),
		.left(p2_left), .right(p2_right), .pos_x(p2_x), .pos_y(p2_y)
	);

	ball_motion u_ball_motion (
		.clock(clock), .reset_n(reset_n), .clear(object_clear), .update(update),
		.p1_x(p1_x), .p1_y(p1_y), .p2_x(p2_x), .p2_y(p2_y),
		.ball_x(ball_x), .ball_y(ball_y)
	);

	rect_raster u_p1_raster (
		.clock(clock), .reset_n(reset_n), .clear(object_clear), .enable(p1_draw),
		.origin_x(p1_x), .origin_y(p1_y),
		.width(pong_pkg::PADDLE_W), .height(pong_pkg::PADDLE_H),
		.pixel_x(p1_px), .pixel_y(p1_py), .done(p1_done)
	);

	rect_raster u_p2_raster (
		.clock(clock), .reset_n(reset_n), .clear(object_clear), .enable(p2_draw),
		.origin_x(p2_x), .origin_y(p2_y),
		.width(pong_pkg::PADDLE_W), .height(pong_pkg::PADDLE_H),
		.pixel_x(p2_px), .pixel_y(p2_py), .done(p2_done)
	);

	rect_raster u_ball_raster (
		.clock(clock), .reset_n(reset_n), .clear(object_clear), .enable(ball_draw),
		.origin_x(ball_x), .origin_y(ball_y),
		.width(pong_pkg::BALL_SIZE), .height(pong_pkg::BALL_SIZE),
		.pixel_x(ball_px), .pixel_y(ball_py), .done(ball_done)
	);

	// only one strobe is high at a time
	always_comb begin
		sel_x = ball_px;
		sel_y = ball_py;
		sel_colour = draw_colour;
		if (border_go) begin
			sel_x = border_px;
			sel_y = border_py;
			sel_colour = pong_pkg::COLOUR_BORDER;
		end else if (p1_draw) begin
			sel_x = p1_px;
			sel_y = p1_py;
		end else if (p2_draw) begin
			sel_x = p2_px;
			sel_y = p2_py;
		end
	end

	// pixel leaves one cycle after the raster issues it
	always_ff @(posedge clock) begin
		x <= sel_x;
		y <= sel_y;
		colour <= sel_colour;
		if (reset_n) begin
			write_en <= 1'b0;
		end else begin
			write_en <= border_go | p1_draw | p2_draw | ball_draw;
		end
	end

endmodule

// File: tests/pong_properties.sv
`timescale 1ns/10ps

module pong_properties (
	input logic             clock,
	input logic             reset_n,
	input logic             object_clear,
	input logic             update,
	input logic             write_en,
	input pong_pkg::coord_t x,
	input pong_pkg::coord_t y
);

	// object_clear is high exactly while the game FSM is in IDLE
	a_no_write_in_idle: assert property (
		@(posedge clock) disable iff (reset_n)
		object_clear |-> !write_en
	) else $error("pixel write while the game is idle");

	a_write_on_screen: assert property (
		@(posedge clock) disable iff (reset_n)
		write_en |-> (x < pong_pkg::SCREEN_W) && (y < pong_pkg::SCREEN_H)
	) else $error("pixel write outside the frame");

	a_update_pulse: assert property (
		@(posedge clock) disable iff (reset_n)
		update |=> !update
	) else $error("update held for more than one cycle");

endmodule

bind pong_top pong_properties u_props (
	.clock(clock), .reset_n(reset_n), .object_clear(object_clear),
	.update(update), .write_en(write_en), .x(x), .y(y)
);

// File: tests/pong_tb.sv
`timescale 1ns/10ps

module pong_tb;

	logic clock;
	logic reset_n;
	logic go;
	logic p1_up;
	logic p1_down;
	logic p1_left;
	logic p1_right;
	logic p2_up;
	logic p2_down;
	logic p2_left;
	logic p2_right;
	pong_pkg::coord_t x;
	pong_pkg::coord_t y;
	pong_pkg::colour_t colour;
	logic write_en;

	// pixel writes seen at the outputs in arrival order
	int wr_x[$];
	int wr_y[$];
	int wr_c[$];

	int checks;
	int errors;
	int timeouts;
	int unsigned lcg_state;

	// topmost row written in the ball colour
	int ball_top;

	// reference model of the game objects
	int m_p1_x;
	int m_p1_y;
	int m_p2_x;
	int m_p2_y;
	int m_ball_x;
	int m_ball_y;
	bit m_right;
	bit m_down;

	pong_top u_dut (
		.clock(clock), .reset_n(reset_n), .go(go),
		.p1_up(p1_up), .p1_down(p1_down), .p1_left(p1_left), .p1_right(p1_right),
		.p2_up(p2_up), .p2_down(p2_down), .p2_left(p2_left), .p2_right(p2_right),
		.x(x), .y(y), .colour(colour), .write_en(write_en)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// outputs change on the rising edge, so sample them on the falling one
	always @(negedge clock) begin
		if (write_en === 1'b1) begin
			wr_x.push_back(int'(x));
			wr_y.push_back(int'(y));
			wr_c.push_back(int'(colour));
			if (colour == pong_pkg::COLOUR_BALL && int'(y) < ball_top) begin
				ball_top = int'(y);
			end
		end
	end

	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return 8'(lcg_state >> 16);
	endfunction

	task automatic check(input string test, input string what, input int expected,
		input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("** Error: %s, %s: expected %0d, actual %0d", test, what, expected, actual);
		end
	endtask

	task automatic end_run();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	task automatic next_write(input string test, output int wx, output int wy, output int wc);
		int waited;
		waited = 0;
		while (wr_x.size() == 0 && waited < 1000) begin
			@(negedge clock);
			waited++;
		end
		if (wr_x.size() == 0) begin
			timeouts++;
			$display("%s: no pixel was written for 1000 cycles", test);
			end_run();
		end else begin
			wx = wr_x.pop_front();
			wy = wr_y.pop_front();
			wc = wr_c.pop_front();
		end
	endtask

	// one rectangle, left to right and top to bottom
	task automatic expect_rect(input string test, input int x0, input int y0, input int w,
		input int h, input int c);
		int row;
		int col;
		int wx;
		int wy;
		int wc;
		int good;
		bit reported;
		good = 0;
		reported = 1'b0;
		for (row = 0; row < h; row++) begin
			for (col = 0; col < w; col++) begin
				next_write(test, wx, wy, wc);
				if (wx == x0 + col && wy == y0 + row && wc == c) begin
					good++;
				end else if (!reported) begin
					reported = 1'b1;
					check(test, "first bad pixel x", x0 + col, wx);
					check(test, "first bad pixel y", y0 + row, wy);
					check(test, "first bad pixel colour", c, wc);
				end
			end
		end
		check(test, "matching pixels", w * h, good);
	endtask

	function automatic int step_axis(input int pos, input bit dec, input bit inc,
		input int hi);
		if (dec && !inc && pos > int'(pong_pkg::PADDLE_MIN)) begin
			return pos - 1;
		end
		if (inc && !dec && pos < hi) begin
			return pos + 1;
		end
		return pos;
	endfunction

	function automatic bit overlaps_paddle(input int px, input int py);
		return m_ball_x < px + int'(pong_pkg::PADDLE_W) &&
			px < m_ball_x + int'(pong_pkg::BALL_SIZE) &&
			m_ball_y < py + int'(pong_pkg::PADDLE_H) &&
			py < m_ball_y + int'(pong_pkg::BALL_SIZE);
	endfunction

	// b is {p2 right, left, down, up, p1 right, left, down, up}
	function automatic void model_update(input logic [7:0] b);
		bit hit;
		hit = overlaps_paddle(m_p1_x, m_p1_y) || overlaps_paddle(m_p2_x, m_p2_y);
		if (m_ball_x == int'(pong_pkg::BALL_MIN)) begin
			m_right = 1'b1;
		end else if (m_ball_x == int'(pong_pkg::BALL_MAX_X)) begin
			m_right = 1'b0;
		end
		if (m_ball_y == int'(pong_pkg::BALL_MIN)) begin
			m_down = 1'b1;
		end else if (m_ball_y == int'(pong_pkg::BALL_MAX_Y)) begin
			m_down = 1'b0;
		end
		if (hit) begin
			m_right = !m_right;
		end
		m_ball_x = m_right ? m_ball_x + 1 : m_ball_x - 1;
		m_ball_y = m_down ? m_ball_y + 1 : m_ball_y - 1;
		m_p1_y = step_axis(m_p1_y, b[0], b[1], int'(pong_pkg::PADDLE_MAX_Y));
		m_p1_x = step_axis(m_p1_x, b[2], b[3], int'(pong_pkg::PADDLE_MAX_X));
		m_p2_y = step_axis(m_p2_y, b[4], b[5], int'(pong_pkg::PADDLE_MAX_Y));
		m_p2_x = step_axis(m_p2_x, b[6], b[7], int'(pong_pkg::PADDLE_MAX_X));
	endfunction

	task automatic set_buttons(input logic [7:0] b);
		@(negedge clock);
		{p2_right, p2_left, p2_down, p2_up, p1_right, p1_left, p1_down, p1_up} = b;
	endtask

	task automatic draw_objects(input string test);
		expect_rect({test, " p1"}, m_p1_x, m_p1_y, int'(pong_pkg::PADDLE_W),
			int'(pong_pkg::PADDLE_H), int'(pong_pkg::COLOUR_P1));
		expect_rect({test, " p2"}, m_p2_x, m_p2_y, int'(pong_pkg::PADDLE_W),
			int'(pong_pkg::PADDLE_H), int'(pong_pkg::COLOUR_P2));
		expect_rect({test, " ball"}, m_ball_x, m_ball_y, int'(pong_pkg::BALL_SIZE),
			int'(pong_pkg::BALL_SIZE), int'(pong_pkg::COLOUR_BALL));
	endtask

	// buttons change during the frame wait and count at the next update
	task automatic erase_objects(input string test, input logic [7:0] b);
		set_buttons(b);
		expect_rect({test, " erase p1"}, m_p1_x, m_p1_y, int'(pong_pkg::PADDLE_W),
			int'(pong_pkg::PADDLE_H), int'(pong_pkg::COLOUR_BLACK));
		expect_rect({test, " erase p2"}, m_p2_x, m_p2_y, int'(pong_pkg::PADDLE_W),
			int'(pong_pkg::PADDLE_H), int'(pong_pkg::COLOUR_BLACK));
		expect_rect({test, " erase ball"}, m_ball_x, m_ball_y, int'(pong_pkg::BALL_SIZE),
			int'(pong_pkg::BALL_SIZE), int'(pong_pkg::COLOUR_BLACK));
		model_update(b);
	endtask

	task automatic run_frame(input string test, input logic [7:0] b);
		draw_objects(test);
		erase_objects(test, b);
	endtask

	task automatic reset_quiet();
		int i;
		int writes;
		writes = 0;
		for (i = 0; i < 50; i++) begin
			@(negedge clock);
			if (write_en !== 1'b0) begin
				writes++;
			end
		end
		check("reset", "cycles with write_en", 0, writes);
	endtask

	task automatic border_strips();
		int side;
		side = int'(pong_pkg::SCREEN_H) - int'(pong_pkg::BORDER_T);
		@(negedge clock);
		go = 1'b1;
		@(negedge clock);
		go = 1'b0;
		expect_rect("border top", 0, 0, int'(pong_pkg::SCREEN_W), int'(pong_pkg::BORDER_T),
			int'(pong_pkg::COLOUR_BORDER));
		expect_rect("border bottom", 0, side, int'(pong_pkg::SCREEN_W),
			int'(pong_pkg::BORDER_T), int'(pong_pkg::COLOUR_BORDER));
		expect_rect("border left", 0, 0, int'(pong_pkg::BORDER_T), int'(pong_pkg::SCREEN_H),
			int'(pong_pkg::COLOUR_BORDER));
		expect_rect("border right", int'(pong_pkg::SCREEN_W) - int'(pong_pkg::BORDER_T), 0,
			int'(pong_pkg::BORDER_T), int'(pong_pkg::SCREEN_H), int'(pong_pkg::COLOUR_BORDER));
	endtask

	task automatic paddle_moves();
		int i;
		for (i = 0; i < 10; i++) begin
			run_frame("paddle hold", 8'h12);
		end
		// p1 right stays released so paddle 1 only drifts left
		for (i = 0; i < 60; i++) begin
			run_frame("paddle random", lcg_next() & 8'hf7);
		end
		for (i = 0; i < 20; i++) begin
			run_frame("paddle left", 8'h04);
		end
		expect_rect("paddle left limit", int'(pong_pkg::PADDLE_MIN), m_p1_y,
			int'(pong_pkg::PADDLE_W), int'(pong_pkg::PADDLE_H), int'(pong_pkg::COLOUR_P1));
		expect_rect("paddle left limit p2", m_p2_x, m_p2_y, int'(pong_pkg::PADDLE_W),
			int'(pong_pkg::PADDLE_H), int'(pong_pkg::COLOUR_P2));
		expect_rect("paddle left limit ball", m_ball_x, m_ball_y, int'(pong_pkg::BALL_SIZE),
			int'(pong_pkg::BALL_SIZE), int'(pong_pkg::COLOUR_BALL));
		erase_objects("paddle left limit", 8'h00);
	endtask

	task automatic ball_moves();
		int i;
		for (i = 0; i < 40; i++) begin
			run_frame("ball", 8'h00);
		end
		// the ball touches the top wall once and turns back
		check("ball", "topmost ball row", int'(pong_pkg::BALL_MIN), ball_top);
	endtask

	initial begin
		checks = 0;
		errors = 0;
		timeouts = 0;
		lcg_state = 26;
		ball_top = int'(pong_pkg::SCREEN_H);
		reset_n = 1'b1;
		go = 1'b0;
		{p2_right, p2_left, p2_down, p2_up, p1_right, p1_left, p1_down, p1_up} = 8'h00;
		m_p1_x = int'(pong_pkg::P1_START_X);
		m_p2_x = int'(pong_pkg::P2_START_X);
		m_p1_y = int'(pong_pkg::PADDLE_START_Y);
		m_p2_y = int'(pong_pkg::PADDLE_START_Y);
		m_ball_x = int'(pong_pkg::BALL_START_X);
		m_ball_y = int'(pong_pkg::BALL_START_Y);
		m_right = 1'b1;
		m_down = 1'b0;
		repeat (3) @(negedge clock);
		reset_n = 1'b0;
		reset_quiet();
		border_strips();
		draw_objects("first frame");
		erase_objects("erase", 8'h00);
		paddle_moves();
		ball_moves();
		end_run();
	end

endmodule

// File: vlog.f
src/pong_pkg.sv
src/rect_raster.sv
src/paddle_motion.sv
src/ball_motion.sv
src/border_painter.sv
src/frame_sequencer.sv
src/pong_top.sv
tests/pong_properties.sv
tests/pong_tb.sv

// File: Makefile
SRCS := $(filter %.sv %.v,$(shell cat vlog.f))

.PHONY: run clean

run: obj_dir/Vpong_tb
	@out="$$(./obj_dir/Vpong_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

obj_dir/Vpong_tb: vlog.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module pong_tb -f vlog.f

clean:
	rm -rf obj_dir
